/* vlog.f */
board_pkg.sv
fan_ch_if.sv
rtc_tick_gen.sv
board_ctrl_regs.sv
fan_channel.sv
fan_status_collector.sv
board_ctrl_top.sv
tb_board_ctrl_props.sv
tb_board_ctrl.sv

/* Makefile */
SIM  := obj_dir/Vtb_board_ctrl
SRCS := $(filter %.sv,$(shell cat vlog.f))

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "tests failed" sim.log

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_board_ctrl -f vlog.f

clean:
	rm -rf obj_dir sim.log

/* tb_board_ctrl.sv */
module tb_board_ctrl
  import board_pkg::*;
();

  localparam logic [31:0] Seed     = 32'he5e7a777;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;
  localparam int ClkHalf     = 10;
  localparam int PwmWindow   = 16 * 2 * RtcHalfDiv;
  localparam int StallSettle = (StallTicks + 4) * RtcHalfDiv;
  // Upper bounds on register traffic including held responses
  localparam int NumTx       = 64;
  localparam int TxCycles    = 16;
  localparam int CycleLimit  = 2 * (PwmWindow + 2 * StallSettle + NumTx * TxCycles);

  logic                    soc_clk = 1'b0;
  logic                    rst_n;
  logic [RegAddrWidth-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [RegDataWidth-1:0] wdata;
  logic [StrbWidth-1:0]    wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [RegAddrWidth-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [RegDataWidth-1:0] rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;
  logic [NumFans-1:0]      fan_tach;
  logic [NumFans-1:0]      fan_pwm;
  logic                    rtc;
  logic                    irq;

  // Reference model of the register state
  logic [DutyWidth-1:0] duty_m [NumFans];
  logic [NumFans-1:0]   en_m;
  logic [NumFans-1:0]   irq_en_m;
  int                   tach_half [NumFans];
  int                   tach_cnt [NumFans];
  logic [31:0]          lfsr_q;
  int                   errors;
  int                   checks;
  int                   rtc_edges;

  always #(ClkHalf) soc_clk = ~soc_clk;

  board_ctrl_top uut (
    .soc_clk   ( soc_clk  ),
    .rst_n     ( rst_n    ),
    .awaddr_i  ( awaddr   ),
    .awvalid_i ( awvalid  ),
    .awready_o ( awready  ),
    .wdata_i   ( wdata    ),
    .wstrb_i   ( wstrb    ),
    .wvalid_i  ( wvalid   ),
    .wready_o  ( wready   ),
    .bresp_o   ( bresp    ),
    .bvalid_o  ( bvalid   ),
    .bready_i  ( bready   ),
    .araddr_i  ( araddr   ),
    .arvalid_i ( arvalid  ),
    .arready_o ( arready  ),
    .rdata_o   ( rdata    ),
    .rresp_o   ( rresp    ),
    .rvalid_o  ( rvalid   ),
    .rready_i  ( rready   ),
    .fan_tach_i( fan_tach ),
    .fan_pwm_o ( fan_pwm  ),
    .rtc_o     ( rtc      ),
    .irq_o     ( irq      )
  );

  ////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LfsrTaps;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  // Fan words, status, mask and ID form one aligned block
  function automatic logic is_mapped(input logic [7:0] addr);
    return (addr <= IdOffset) && (addr[1:0] == 2'b00);
  endfunction

  function automatic logic [7:0] fan_addr(input int ch);
    return FanCfgBase + 8'(4 * ch);
  endfunction

  function automatic logic [31:0] expected_cfg(input int ch);
    logic [31:0] word;
    word                = '0;
    word[DutyWidth-1:0] = duty_m[ch];
    word[DutyWidth]     = en_m[ch];
    return word;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // AXI4-Lite driver

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input int hold, output logic [1:0] resp);
    @(posedge soc_clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    @(negedge soc_clk);
    while (!awready) @(negedge soc_clk);
    compare_word("wready on handshake", 32'd1, 32'(wready));
    @(posedge soc_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge soc_clk);
    while (!bvalid) @(negedge soc_clk);
    resp = bresp;
    // Retry the request while the response is held back
    for (int c = 0; c < hold; c++) begin
      @(posedge soc_clk);
      #1;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge soc_clk);
      compare_word("bvalid held", 32'd1, 32'(bvalid));
      compare_word("bresp held", 32'(resp), 32'(bresp));
      compare_word("awready while pending", 32'd0, 32'(awready));
      compare_word("wready while pending", 32'd0, 32'(wready));
    end
    @(posedge soc_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(posedge soc_clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input int hold,
                          output logic [31:0] data, output logic [1:0] resp);
    @(posedge soc_clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    @(negedge soc_clk);
    while (!arready) @(negedge soc_clk);
    @(posedge soc_clk);
    #1;
    arvalid = 1'b0;
    @(negedge soc_clk);
    while (!rvalid) @(negedge soc_clk);
    data = rdata;
    resp = rresp;
    for (int c = 0; c < hold; c++) begin
      @(posedge soc_clk);
      #1;
      arvalid = 1'b1;
      @(negedge soc_clk);
      compare_word("rvalid held", 32'd1, 32'(rvalid));
      compare_word("rdata held", data, rdata);
      compare_word("rresp held", 32'(resp), 32'(rresp));
      compare_word("arready while pending", 32'd0, 32'(arready));
    end
    @(posedge soc_clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(posedge soc_clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_check(input string name, input logic [7:0] addr,
                             input logic [31:0] data, input logic [1:0] exp_resp);
    logic [1:0] resp;
    write_reg(addr, data, 0, resp);
    compare_word({name, " bresp"}, 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, 0, data, resp);
    compare_word(name, exp_data, data);
    compare_word({name, " rresp"}, 32'(exp_resp), 32'(resp));
  endtask

  task automatic verify_cfg_regs(input string name);
    for (int i = 0; i < NumFans; i++) begin
      read_check(name, fan_addr(i), expected_cfg(i), RespOkay);
    end
    read_check(name, IrqEnOffset, 32'(irq_en_m), RespOkay);
  endtask

  ////////////////////////////////////////
  // Tach stimulus
  // Half period in ticks where 0 holds the level

  initial begin : tach_drive
    fan_tach = '0;
    for (int i = 0; i < NumFans; i++) begin
      tach_cnt[i] = 0;
    end
    forever begin
      @(posedge soc_clk);
      #1;
      for (int i = 0; i < NumFans; i++) begin
        if (tach_half[i] == 0) begin
          tach_cnt[i] = 0;
        end else if (tach_cnt[i] >= tach_half[i] * RtcHalfDiv - 1) begin
          tach_cnt[i] = 0;
          fan_tach[i] = ~fan_tach[i];
        end else begin
          tach_cnt[i]++;
        end
      end
    end
  end

  // RTC half period measured from reset release
  initial begin : rtc_monitor
    int   since;
    logic prev;
    wait (rst_n === 1'b1);
    @(posedge soc_clk);
    since = 0;
    prev  = rtc;
    forever begin
      @(negedge soc_clk);
      since++;
      if (rtc !== prev) begin
        compare_word("rtc half period", 32'(RtcHalfDiv), 32'(since));
        rtc_edges++;
        since = 0;
        prev  = rtc;
      end
    end
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge soc_clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles", cycle_cnt);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence

  initial begin : main
    logic [7:0]         addr;
    logic [31:0]        data;
    logic [1:0]         resp;
    logic [NumFans-1:0] stop_mask;
    logic [NumFans-1:0] clear_sel;
    logic [NumFans-1:0] stall_exp;
    logic               rtc_prev;
    int                 high_cnt [NumFans];
    int                 exp_hi;
    int                 hold;
    int                 ch;

    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr_q  = Seed;
    irq_en_m = '0;
    for (int i = 0; i < NumFans; i++) begin
      tach_half[i] = 0;
      duty_m[i]    = '0;
      en_m[i]      = 1'b0;
    end
    repeat (2) @(posedge soc_clk);
    @(negedge soc_clk);
    compare_word("irq in reset", 32'd0, 32'(irq));
    compare_word("rtc in reset", 32'd0, 32'(rtc));
    compare_word("pwm in reset", 32'd0, 32'(fan_pwm));
    @(posedge soc_clk);
    #1;
    rst_n = 1'b1;

    // Register round trip
    for (int i = 0; i < NumFans; i++) begin
      duty_m[i] = DutyWidth'(take_rand_bits(DutyWidth));
      en_m[i]   = 1'(take_rand_bits(1));
      write_check("cfg write", fan_addr(i), expected_cfg(i), RespOkay);
    end
    irq_en_m = NumFans'(take_rand_bits(NumFans));
    write_check("irq_en write", IrqEnOffset, 32'(irq_en_m), RespOkay);
    verify_cfg_regs("round trip");
    read_check("id read", IdOffset, BoardIdCode, RespOkay);

    // Error slave
    for (int n = 0; n < 4; n++) begin
      do begin
        addr = 8'(take_rand_bits(8));
      end while (is_mapped(addr));
      read_check("unmapped read", addr, ErrWord, RespSlvErr);
    end
    data = take_rand_bits(32);
    write_check("id write", IdOffset, data, RespSlvErr);
    do begin
      addr = 8'(take_rand_bits(8));
    end while (is_mapped(addr));
    write_check("unmapped write", addr, data, RespSlvErr);
    verify_cfg_regs("after error writes");
    read_check("id after write", IdOffset, BoardIdCode, RespOkay);

    // PWM duty over two full periods
    @(negedge soc_clk);
    rtc_prev = rtc;
    while (rtc === rtc_prev) @(negedge soc_clk);
    for (int i = 0; i < NumFans; i++) begin
      high_cnt[i] = 0;
    end
    repeat (PwmWindow) begin
      for (int i = 0; i < NumFans; i++) begin
        if (fan_pwm[i]) begin
          high_cnt[i]++;
        end
      end
      @(negedge soc_clk);
    end
    for (int i = 0; i < NumFans; i++) begin
      exp_hi = en_m[i] ? int'(duty_m[i]) * RtcHalfDiv * 2 : 0;
      compare_word("pwm high cycles", 32'(exp_hi), 32'(high_cnt[i]));
    end

    // Stall and interrupt
    stop_mask = NumFans'(take_rand_bits(NumFans));
    if (stop_mask == '0 || stop_mask == '1) begin
      stop_mask = NumFans'(5);
    end
    for (int i = 0; i < NumFans; i++) begin
      duty_m[i] = DutyWidth'(take_rand_bits(DutyWidth));
      if (duty_m[i] == '0) begin
        duty_m[i] = DutyWidth'(1);
      end
      en_m[i] = 1'b1;
      write_check("cfg enable", fan_addr(i), expected_cfg(i), RespOkay);
      // Running fans see a rising edge at most every 4 ticks
      tach_half[i] = stop_mask[i] ? 0 : 1 + int'(take_rand_bits(1));
    end
    repeat ((StallTicks + 2) * RtcHalfDiv) @(posedge soc_clk);
    write_check("status clear all", StatusOffset, 32'((1 << NumFans) - 1), RespOkay);
    irq_en_m = NumFans'(take_rand_bits(NumFans));
    // At least one stalled channel reaches the interrupt
    if ((irq_en_m & stop_mask) == '0) begin
      irq_en_m = irq_en_m | stop_mask;
    end
    write_check("irq_en write", IrqEnOffset, 32'(irq_en_m), RespOkay);
    repeat (StallSettle) @(posedge soc_clk);
    stall_exp = stop_mask;
    read_check("stall status", StatusOffset, 32'(stall_exp), RespOkay);
    @(negedge soc_clk);
    compare_word("irq after stall", 32'(|(stall_exp & irq_en_m)), 32'(irq));

    // Disabled channels keep their flags but set no new ones
    for (int i = 0; i < NumFans; i++) begin
      en_m[i] = 1'b0;
      write_check("cfg disable", fan_addr(i), expected_cfg(i), RespOkay);
    end
    read_check("status after disable", StatusOffset, 32'(stall_exp), RespOkay);
    clear_sel = NumFans'(take_rand_bits(NumFans));
    // Clear at least one stalled channel
    if ((clear_sel & stall_exp) == '0) begin
      clear_sel = clear_sel | (stall_exp & (~stall_exp + 1'b1));
    end
    write_check("status w1c", StatusOffset, 32'(clear_sel), RespOkay);
    stall_exp = stall_exp & ~clear_sel;
    read_check("status after w1c", StatusOffset, 32'(stall_exp), RespOkay);
    @(negedge soc_clk);
    compare_word("irq after w1c", 32'(|(stall_exp & irq_en_m)), 32'(irq));
    for (int i = 0; i < NumFans; i++) begin
      tach_half[i] = 0;
    end

    // Back-pressure on both response channels
    for (int n = 0; n < 4; n++) begin
      ch         = int'(take_rand_bits(FanIdxWidth));
      duty_m[ch] = DutyWidth'(take_rand_bits(DutyWidth));
      en_m[ch]   = 1'(take_rand_bits(1));
      hold       = 1 + int'(take_rand_bits(3));
      write_reg(fan_addr(ch), expected_cfg(ch), hold, resp);
      compare_word("held write bresp", 32'(RespOkay), 32'(resp));
      hold = 1 + int'(take_rand_bits(3));
      read_reg(fan_addr(ch), hold, data, resp);
      compare_word("held read data", expected_cfg(ch), data);
      compare_word("held read rresp", 32'(RespOkay), 32'(resp));
    end
    do begin
      addr = 8'(take_rand_bits(8));
    end while (is_mapped(addr));
    hold = 1 + int'(take_rand_bits(3));
    read_reg(addr, hold, data, resp);
    compare_word("held error data", ErrWord, data);
    compare_word("held error rresp", 32'(RespSlvErr), 32'(resp));

    checks++;
    assert (rtc_edges >= 10) else begin
      errors++;
      $display("RTC output toggled only %0d times during the run", rtc_edges);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tb_board_ctrl_props.sv */
module tb_board_ctrl_props
  import board_pkg::*;
(
  input logic               soc_clk,
  input logic               rst_n,
  input logic               awready_i,
  input logic               arready_i,
  input logic               bvalid_i,
  input logic               bready_i,
  input logic               rvalid_i,
  input logic               rready_i,
  input logic [NumFans-1:0] irq_en_i
);

  // No new request while a response waits
  a_aw_blocked: assert property (@(posedge soc_clk) disable iff (!rst_n)
    bvalid_i |-> !awready_i)
    else $error("write request accepted while a write response was pending");

  a_ar_blocked: assert property (@(posedge soc_clk) disable iff (!rst_n)
    rvalid_i |-> !arready_i)
    else $error("read request accepted while a read response was pending");

  // Responses hold until taken
  a_b_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  a_r_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  a_reset: assert property (@(posedge soc_clk)
    !rst_n |=> !bvalid_i && !rvalid_i && (irq_en_i == '0))
    else $error("response valid or interrupt mask set during reset");

endmodule

bind board_ctrl_regs tb_board_ctrl_props i_props (
  .soc_clk   ( soc_clk   ),
  .rst_n     ( rst_n     ),
  .awready_i ( awready_o ),
  .arready_i ( arready_o ),
  .bvalid_i  ( bvalid_o  ),
  .bready_i  ( bready_i  ),
  .rvalid_i  ( rvalid_o  ),
  .rready_i  ( rready_i  ),
  .irq_en_i  ( irq_en_o  )
);

/* board_ctrl_top.sv */
module board_ctrl_top
  import board_pkg::*;
(
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic [RegAddrWidth-1:0] awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  logic [RegDataWidth-1:0] wdata_i,
  input  logic [StrbWidth-1:0]    wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output logic [1:0]              bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  logic [RegAddrWidth-1:0] araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output logic [RegDataWidth-1:0] rdata_o,
  output logic [1:0]              rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  input  logic [NumFans-1:0]      fan_tach_i,
  output logic [NumFans-1:0]      fan_pwm_o,
  output logic                    rtc_o,
  output logic                    irq_o
);

  logic               step_tick;
  logic [NumFans-1:0] stall_vec;
  logic [NumFans-1:0] irq_en;

  fan_ch_if fan_if [NumFans] ();

  ////////////////////////////////////////
  // RTC and step tick

  rtc_tick_gen i_rtc_tick_gen (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .step_tick_o ( step_tick ),
    .rtc_o       ( rtc_o     )
  );

  ////////////////////////////////////////
  // Register slave

  board_ctrl_regs i_board_ctrl_regs (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .awaddr_i    ( awaddr_i  ),
    .awvalid_i   ( awvalid_i ),
    .awready_o   ( awready_o ),
    .wdata_i     ( wdata_i   ),
    .wstrb_i     ( wstrb_i   ),
    .wvalid_i    ( wvalid_i  ),
    .wready_o    ( wready_o  ),
    .bresp_o     ( bresp_o   ),
    .bvalid_o    ( bvalid_o  ),
    .bready_i    ( bready_i  ),
    .araddr_i    ( araddr_i  ),
    .arvalid_i   ( arvalid_i ),
    .arready_o   ( arready_o ),
    .rdata_o     ( rdata_o   ),
    .rresp_o     ( rresp_o   ),
    .rvalid_o    ( rvalid_o  ),
    .rready_i    ( rready_i  ),
    .stall_vec_i ( stall_vec ),
    .irq_en_o    ( irq_en    ),
    .fan         ( fan_if    )
  );

  ////////////////////////////////////////
  // Fan channels

  for (genvar i = 0; i < NumFans; i++) begin : g_fan
    fan_channel i_fan_channel (
      .soc_clk     ( soc_clk       ),
      .rst_n       ( rst_n         ),
      .step_tick_i ( step_tick     ),
      .tach_i      ( fan_tach_i[i] ),
      .fan_pwm_o   ( fan_pwm_o[i]  ),
      .ch          ( fan_if[i]     )
    );
  end

  // Stall flags back to status and interrupt
  fan_status_collector i_fan_status_collector (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .fan         ( fan_if    ),
    .irq_en_i    ( irq_en    ),
    .stall_vec_o ( stall_vec ),
    .irq_o       ( irq_o     )
  );

endmodule

/* fan_status_collector.sv */
module fan_status_collector
  import board_pkg::*;
(
  input  logic               soc_clk,
  input  logic               rst_n,
  fan_ch_if.mon              fan [NumFans],
  input  logic [NumFans-1:0] irq_en_i,
  output logic [NumFans-1:0] stall_vec_o,
  output logic               irq_o
);

  logic [NumFans-1:0] stall_vec;
  logic               irq_q;

  // One status bit per channel
  for (genvar i = 0; i < NumFans; i++) begin : g_pack
    assign stall_vec[i] = fan[i].stall;
  end

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= |(stall_vec & irq_en_i);
    end
  end

  assign stall_vec_o = stall_vec;
  assign irq_o       = irq_q;

endmodule

/* fan_channel.sv */
module fan_channel
  import board_pkg::*;
(
  input  logic    soc_clk,
  input  logic    rst_n,
  input  logic    step_tick_i,
  input  logic    tach_i,
  output logic    fan_pwm_o,
  fan_ch_if.chan  ch
);

  logic [DutyWidth-1:0]     phase_q;
  logic                     pwm_q;
  logic                     tach_meta_q;
  logic                     tach_sync_q;
  logic                     tach_prev_q;
  logic                     tach_rise;
  logic                     active;
  logic [StallCntWidth-1:0] stall_cnt_q;
  logic                     stall_hit;
  logic                     stall_q;

  ////////////////////////////////////////
  // PWM

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      if (step_tick_i) begin
        phase_q <= phase_q + 1'b1;
      end
      // High for duty steps out of every 16
      pwm_q <= ch.enable && (phase_q < ch.duty);
    end
  end

  assign fan_pwm_o = pwm_q;

  ////////////////////////////////////////
  // Tach sync and stall timer

  assign tach_rise = tach_sync_q & ~tach_prev_q;
  // A stopped or zero-duty fan is not expected to spin
  assign active    = ch.enable && (ch.duty != '0);
  assign stall_hit = active && !tach_rise && step_tick_i &&
                     (stall_cnt_q == StallCntWidth'(StallTicks - 1));

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      tach_meta_q <= 1'b0;
      tach_sync_q <= 1'b0;
      tach_prev_q <= 1'b0;
      stall_cnt_q <= '0;
      stall_q     <= 1'b0;
    end else begin
      tach_meta_q <= tach_i;
      tach_sync_q <= tach_meta_q;
      tach_prev_q <= tach_sync_q;

      if (!active || tach_rise || stall_hit) begin
        stall_cnt_q <= '0;
      end else if (step_tick_i) begin
        stall_cnt_q <= stall_cnt_q + 1'b1;
      end

      // A new stall wins over a clear in the same cycle
      if (stall_hit) begin
        stall_q <= 1'b1;
      end else if (ch.stall_clr) begin
        stall_q <= 1'b0;
      end
    end
  end

  assign ch.stall = stall_q;

endmodule

/* board_ctrl_regs.sv */
module board_ctrl_regs
  import board_pkg::*;
(
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic [RegAddrWidth-1:0] awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  logic [RegDataWidth-1:0] wdata_i,
  input  logic [StrbWidth-1:0]    wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output logic [1:0]              bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  logic [RegAddrWidth-1:0] araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output logic [RegDataWidth-1:0] rdata_o,
  output logic [1:0]              rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  input  logic [NumFans-1:0]      stall_vec_i,
  output logic [NumFans-1:0]      irq_en_o,
  fan_ch_if.cfg                   fan [NumFans]
);

  logic [DutyWidth-1:0]    duty_q [NumFans];
  logic [NumFans-1:0]      en_q;
  logic [NumFans-1:0]      irq_en_q;
  logic [NumFans-1:0]      stall_clr_q;
  logic                    bvalid_q;
  logic                    rvalid_q;
  logic [1:0]              bresp_q;
  logic [1:0]              rresp_q;
  logic [RegDataWidth-1:0] rdata_q;

  logic                    wr_hs;
  logic                    rd_hs;
  logic [RegAddrWidth-1:0] wr_off;
  logic [RegAddrWidth-1:0] rd_off;
  logic                    wr_fan;
  logic                    wr_status;
  logic                    wr_irq_en;
  logic [FanIdxWidth-1:0]  wr_idx;
  logic [FanIdxWidth-1:0]  rd_idx;
  logic [RegDataWidth-1:0] rd_word;
  logic [1:0]              rd_resp;

  ////////////////////////////////////////
  // Handshakes, one transaction per channel

  assign wr_hs     = awvalid_i & wvalid_i & ~bvalid_q;
  assign rd_hs     = arvalid_i & ~rvalid_q;
  assign awready_o = wr_hs;
  assign wready_o  = wr_hs;
  assign arready_o = rd_hs;

  ////////////////////////////////////////
  // Address decode

  // Fan config words are contiguous from FanCfgBase
  assign wr_off = awaddr_i - FanCfgBase;
  assign rd_off = araddr_i - FanCfgBase;
  assign wr_idx = wr_off[FanIdxWidth+1:2];
  assign rd_idx = rd_off[FanIdxWidth+1:2];

  assign wr_fan    = (wr_off < FanCfgSpan) && (wr_off[1:0] == 2'b00);
  assign wr_status = (awaddr_i == StatusOffset);
  assign wr_irq_en = (awaddr_i == IrqEnOffset);

  always_comb begin
    rd_word = ErrWord;
    rd_resp = RespSlvErr;
    if ((rd_off < FanCfgSpan) && (rd_off[1:0] == 2'b00)) begin
      rd_word                  = '0;
      rd_word[DutyWidth-1:0]   = duty_q[rd_idx];
      rd_word[DutyWidth]       = en_q[rd_idx];
      rd_resp                  = RespOkay;
    end else begin
      case (araddr_i)
        StatusOffset: begin
          rd_word = RegDataWidth'(stall_vec_i);
          rd_resp = RespOkay;
        end
        IrqEnOffset: begin
          rd_word = RegDataWidth'(irq_en_q);
          rd_resp = RespOkay;
        end
        IdOffset: begin
          rd_word = BoardIdCode;
          rd_resp = RespOkay;
        end
        default: begin
          rd_word = ErrWord;
          rd_resp = RespSlvErr;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Registers and response state

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NumFans; i++) begin
        duty_q[i] <= '0;
      end
      en_q        <= '0;
      irq_en_q    <= '0;
      stall_clr_q <= '0;
      bvalid_q    <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      // Clear strobes last a single cycle
      stall_clr_q <= '0;
      // All fields sit in the low byte
      if (wr_hs && wstrb_i[0]) begin
        if (wr_fan) begin
          duty_q[wr_idx] <= wdata_i[DutyWidth-1:0];
          en_q[wr_idx]   <= wdata_i[DutyWidth];
        end
        if (wr_status) begin
          stall_clr_q <= wdata_i[NumFans-1:0];
        end
        if (wr_irq_en) begin
          irq_en_q <= wdata_i[NumFans-1:0];
        end
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload, held while valid waits
  always_ff @(posedge soc_clk) begin
    if (wr_hs) begin
      bresp_q <= (wr_fan || wr_status || wr_irq_en) ? RespOkay : RespSlvErr;
    end
    if (rd_hs) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;
  assign irq_en_o = irq_en_q;

  for (genvar i = 0; i < NumFans; i++) begin : g_cfg
    assign fan[i].duty      = duty_q[i];
    assign fan[i].enable    = en_q[i];
    assign fan[i].stall_clr = stall_clr_q[i];
  end

endmodule

/* rtc_tick_gen.sv */
module rtc_tick_gen
  import board_pkg::*;
(
  input  logic soc_clk,
  input  logic rst_n,
  output logic step_tick_o,
  output logic rtc_o
);

  logic [RtcCntWidth-1:0] cnt_q;
  logic                   wrap;
  logic                   tick_q;
  logic                   rtc_q;

  // Last cycle of a half period
  assign wrap = (cnt_q == RtcCntWidth'(RtcHalfDiv - 1));

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
      rtc_q  <= 1'b0;
    end else begin
      tick_q <= wrap;
      if (wrap) begin
        cnt_q <= '0;
        rtc_q <= ~rtc_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Tick and RTC edge line up on the same cycle
  assign step_tick_o = tick_q;
  assign rtc_o       = rtc_q;

endmodule

/* fan_ch_if.sv */
interface fan_ch_if
  import board_pkg::*;
();

  // Configuration from the register block
  logic [DutyWidth-1:0] duty;
  logic                 enable;
  logic                 stall_clr;

  // Sticky stall flag from the channel
  logic                 stall;

  modport cfg (
    output duty,
    output enable,
    output stall_clr
  );

  modport chan (
    input  duty,
    input  enable,
    input  stall_clr,
    output stall
  );

  modport mon (
    input  stall
  );

endinterface

/* board_pkg.sv */
package board_pkg;

  ////////////////////////////////////////
  // Sizes and dividers

  localparam int NumFans     = 4;
  localparam int FanIdxWidth = $clog2(NumFans);
  localparam int DutyWidth   = 4;

  // Cycles per RTC half period, also the PWM step period
  localparam int RtcHalfDiv  = 25;
  localparam int RtcCntWidth = $clog2(RtcHalfDiv);

  // Step ticks without a tach edge before a fan counts as stalled
  localparam int StallTicks    = 8;
  localparam int StallCntWidth = $clog2(StallTicks);

  ////////////////////////////////////////
  // Register bus

  localparam int RegAddrWidth = 8;
  localparam int RegDataWidth = 32;
  localparam int StrbWidth    = RegDataWidth / 8;

  // Register map
  localparam logic [RegAddrWidth-1:0] FanCfgBase   = 'h00;
  localparam logic [RegAddrWidth-1:0] FanCfgSpan   = RegAddrWidth'(4 * NumFans);
  localparam logic [RegAddrWidth-1:0] StatusOffset = 'h10;
  localparam logic [RegAddrWidth-1:0] IrqEnOffset  = 'h14;
  localparam logic [RegAddrWidth-1:0] IdOffset     = 'h18;

  localparam logic [RegDataWidth-1:0] BoardIdCode = 32'hB0A2_C7F1;
  // Returned for reads that hit no register
  localparam logic [RegDataWidth-1:0] ErrWord     = 32'hBADCAB1E;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

endpackage
